/* rv_core.f */
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_stage_reg.sv
design/rv_execute.sv
design/rv_core_top.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_rv_core -f rv_core.f

out=$(./obj_dir/Vtb_rv_core 2>&1) || true
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int clk_half  = 4;
    localparam int drain_max = 20;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        flush;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] model_regs [32];   // architectural state, in issue order
    string       exp_name [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    int          seed = 67126;
    string       r_names [8] = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and"};

    rv_core_top DUT (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .i_flush       (flush),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // ------------------------------------------------------------
    // encoders and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic f7b, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, f7b, 5'b00000, rs2, rs1, f3, rd, rv_pkg::op_r_type};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::op_i_alu};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    function automatic logic [31:0] expect_result(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        is_r;
        is_r = (ins[6:0] == rv_pkg::op_r_type);
        a    = model_regs[ins[19:15]];
        b    = is_r ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sh   = b[4:0];
        if (ins[6:0] == rv_pkg::op_lui)
            return {ins[31:12], 12'b0};
        case (ins[14:12])
            3'd0:    return (is_r && ins[30]) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return ins[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ------------------------------------------------------------
    // failure reporting
    // ------------------------------------------------------------
    task automatic end_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic stop_run(input string what);
        $display("ERROR: %s", what);
        end_run();
    endtask

    task automatic fail_value(input string name, input logic [4:0] e_rd,
                              input logic [31:0] e_val);
        $display("[FAIL] %s: expected x%0d = 0x%08h, actual x%0d = 0x%08h",
                 name, e_rd, e_val, wb_rd, wb_data);
        end_run();
    endtask

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    task automatic issue(input logic [31:0] ins, input string name, input logic kill);
        logic [6:0]  op;
        logic [31:0] value;
        op    = ins[6:0];
        value = expect_result(ins);
        instr_valid = 1'b1;
        instr       = ins;
        flush       = kill;
        if (!kill && (op == rv_pkg::op_r_type || op == rv_pkg::op_i_alu ||
                      op == rv_pkg::op_lui)) begin
            exp_name.push_back(name);
            exp_rd.push_back(ins[11:7]);
            exp_val.push_back(value);
            if (ins[11:7] != 5'd0)
                model_regs[ins[11:7]] = value;   // x0 stays zero
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        flush       = 1'b0;
    endtask

    task automatic bubble();
        @(posedge clk);
        #1;
    endtask

    // lui + addi, the +0x800 undoes the sign of the low part
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value, input string name);
        logic [31:0] upper;
        upper = value + 32'h0000_0800;
        issue(enc_lui(upper[31:12], rd), name, 1'b0);
        issue(enc_i(value[11:0], rd, 3'd0, rd), name, 1'b0);
    endtask

    // ------------------------------------------------------------
    // writeback checker
    // ------------------------------------------------------------
    always @(negedge clk) begin : check_wb
        string       name;
        logic [4:0]  e_rd;
        logic [31:0] e_val;
        if (!rst && wb_valid) begin
            if (exp_rd.size() == 0) begin
                stop_run("writeback seen with no instruction outstanding");
            end else begin
                name  = exp_name.pop_front();
                e_rd  = exp_rd.pop_front();
                e_val = exp_val.pop_front();
                assert (wb_rd == e_rd && wb_data == e_val)
                    else fail_value(name, e_rd, e_val);
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.u_asserts.fail_seen)
            stop_run("an assertion bound to the core fired");
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic [11:0] imm;
        logic [4:0]  sh;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        flush       = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) bubble();   // idle core after reset

        // every alu op over random operands
        for (int n = 0; n < 8; n++) begin
            a_val = $random(seed);
            b_val = $random(seed);
            load_reg(5'd1, a_val, "load x1");
            load_reg(5'd2, b_val, "load x2");
            for (int f = 0; f < 8; f++) begin
                issue(enc_r(1'b0, 5'd2, 5'd1, f[2:0], 5'(8 + f)), r_names[f], 1'b0);
                imm = 12'($random(seed));
                sh  = 5'($random(seed));
                if (f == 1 || f == 5)
                    imm = {7'b0000000, sh};
                issue(enc_i(imm, 5'd1, f[2:0], 5'(16 + f)), {r_names[f], "i"}, 1'b0);
                if (($random(seed) & 3) == 0)
                    bubble();
            end
            issue(enc_r(1'b1, 5'd2, 5'd1, 3'd0, 5'd24), "sub", 1'b0);
            issue(enc_r(1'b1, 5'd2, 5'd1, 3'd5, 5'd25), "sra", 1'b0);
            sh = 5'($random(seed));
            issue(enc_i({7'b0100000, sh}, 5'd1, 3'd5, 5'd26), "srai", 1'b0);
            issue(enc_lui(20'($random(seed)), 5'd27), "lui", 1'b0);
        end

        // dependent pairs at distance one, two and three
        issue(enc_r(1'b0, 5'd2, 5'd1, 3'd0, 5'd5), "dep producer", 1'b0);
        issue(enc_r(1'b1, 5'd1, 5'd5, 3'd0, 5'd6), "dep distance 1 rs1", 1'b0);
        issue(enc_r(1'b0, 5'd6, 5'd6, 3'd0, 5'd6), "dep distance 1 both", 1'b0);
        issue(enc_i(12'h007, 5'd5, 3'd0, 5'd5), "dep producer", 1'b0);
        issue(enc_r(1'b0, 5'd2, 5'd1, 3'd6, 5'd7), "dep filler", 1'b0);
        issue(enc_r(1'b0, 5'd5, 5'd2, 3'd0, 5'd6), "dep distance 2 rs2", 1'b0);
        issue(enc_i(12'h003, 5'd5, 3'd1, 5'd5), "dep producer", 1'b0);
        issue(enc_r(1'b0, 5'd2, 5'd1, 3'd4, 5'd7), "dep filler", 1'b0);
        issue(enc_r(1'b0, 5'd2, 5'd1, 3'd7, 5'd7), "dep filler", 1'b0);
        issue(enc_r(1'b0, 5'd1, 5'd5, 3'd3, 5'd6), "dep distance 3", 1'b0);

        // x0 writes show on the outputs but are not kept
        issue(enc_i(12'h005, 5'd1, 3'd0, 5'd0), "write x0", 1'b0);
        issue(enc_r(1'b0, 5'd0, 5'd0, 3'd0, 5'd9), "read x0 distance 1", 1'b0);
        issue(enc_r(1'b0, 5'd1, 5'd0, 3'd0, 5'd9), "read x0 distance 2", 1'b0);

        // flushed write must not land
        issue(enc_i(12'h07b, 5'd0, 3'd0, 5'd20), "flush setup", 1'b0);
        issue(enc_i(12'h3e7, 5'd0, 3'd0, 5'd20), "flushed write", 1'b1);
        issue(enc_r(1'b0, 5'd0, 5'd20, 3'd0, 5'd21), "read after flush", 1'b0);
        bubble();
        issue(enc_i(12'h000, 5'd20, 3'd0, 5'd22), "late read after flush", 1'b0);

        // a load opcode is not supported and retires nothing
        issue(32'h0000_2083, "unsupported opcode", 1'b0);

        for (int i = 0; i < drain_max && exp_rd.size() != 0; i++)
            @(posedge clk);
        repeat (3) @(posedge clk);
        if (exp_rd.size() != 0) begin
            stop_run("timed out waiting for outstanding writebacks");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* bench/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_instr_valid,
    input  logic i_flush,
    input  logic i_dec_valid,   // decoded payload valid, opcode supported
    input  logic i_wb_valid
);

    logic seen_instr;
    logic fail_reset  = 1'b0;
    logic fail_idle   = 1'b0;
    logic fail_retire = 1'b0;
    logic fail_kill   = 1'b0;
    logic fail_stray  = 1'b0;
    logic fail_seen;

    assign fail_seen = fail_reset | fail_idle | fail_retire | fail_kill | fail_stray;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            seen_instr <= 1'b0;
        end else if (i_instr_valid) begin
            seen_instr <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // reset
    // ------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge i_clk) i_rst |-> !i_wb_valid)
        else begin
            fail_reset = 1'b1;
            $error("writeback valid while reset is held");
        end

    // nothing retires before the first instruction
    a_idle_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
        !seen_instr |-> !i_wb_valid)
        else begin
            fail_idle = 1'b1;
            $error("writeback valid before any instruction was sent");
        end

    // ------------------------------------------------------------
    // two edge latency and flush
    // ------------------------------------------------------------
    a_retire: assert property (@(posedge i_clk) disable iff (i_rst)
        $past(i_dec_valid && !i_flush, 2) |-> i_wb_valid)
        else begin
            fail_retire = 1'b1;
            $error("instruction did not retire two edges after it was taken");
        end

    a_kill: assert property (@(posedge i_clk) disable iff (i_rst)
        $past(i_flush, 2) |-> !i_wb_valid)
        else begin
            fail_kill = 1'b1;
            $error("flushed instruction reached writeback");
        end

    a_stray: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_valid |-> $past(i_dec_valid, 2))
        else begin
            fail_stray = 1'b1;
            $error("writeback valid without a matching instruction");
        end

endmodule

bind rv_core_top rv_core_asserts u_asserts (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_instr_valid (i_instr_valid),
    .i_flush       (i_flush),
    .i_dec_valid   (ex_d.valid),
    .i_wb_valid    (o_wb_valid)
);

/* design/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_instr_valid,
    input  logic [rv_pkg::xlen-1:0]       i_instr,
    input  logic                          i_flush,
    output logic                          o_wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] o_wb_rd,
    output logic [rv_pkg::xlen-1:0]       o_wb_data
);

    logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_pkg::xlen-1:0]       rs1_data;
    logic [rv_pkg::xlen-1:0]       rs2_data;
    rv_pkg::ex_payload_t           ex_d;
    rv_pkg::ex_payload_t           ex_q;
    rv_pkg::wb_payload_t           wb_d;
    rv_pkg::wb_payload_t           wb_q;

    // ------------------------------------------------------------
    // decode and register read
    // ------------------------------------------------------------
    rv_decode u_decode (
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_rs1_addr    (rs1_addr),
        .o_rs2_addr    (rs2_addr),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .o_ex          (ex_d)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wb       (wb_q)
    );

    rv_stage_reg #(.payload_t(rv_pkg::ex_payload_t)) u_ex_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_flush (i_flush),
        .i_d     (ex_d),
        .o_q     (ex_q)
    );

    // ------------------------------------------------------------
    // execute and writeback
    // ------------------------------------------------------------
    rv_execute u_execute (
        .i_ex (ex_q),
        .i_wb (wb_q),
        .o_wb (wb_d)
    );

    // flush port omitted, reset-only clearing
    rv_stage_reg #(.payload_t(rv_pkg::wb_payload_t)) u_wb_reg (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_d   (wb_d),
        .o_q   (wb_q)
    );

    assign o_wb_valid = wb_q.valid;
    assign o_wb_rd    = wb_q.rd;
    assign o_wb_data  = wb_q.result;

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::ex_payload_t i_ex,
    input  rv_pkg::wb_payload_t i_wb,
    output rv_pkg::wb_payload_t o_wb
);

    logic                       wb_live;
    logic                       fwd_a;
    logic                       fwd_b;
    logic [rv_pkg::xlen-1:0]    rs1_val;
    logic [rv_pkg::xlen-1:0]    rs2_val;
    logic [rv_pkg::xlen-1:0]    op_a;
    logic [rv_pkg::xlen-1:0]    op_b;
    logic [rv_pkg::shamt_w-1:0] shamt;
    logic [rv_pkg::xlen-1:0]    result;

    // ------------------------------------------------------------
    // forward from writeback
    // ------------------------------------------------------------
    assign wb_live = i_wb.valid && (i_wb.rd != '0);
    assign fwd_a   = wb_live && (i_wb.rd == i_ex.rs1);
    assign fwd_b   = wb_live && (i_wb.rd == i_ex.rs2);

    assign rs1_val = fwd_a ? i_wb.result : i_ex.rs1_data;
    assign rs2_val = fwd_b ? i_wb.result : i_ex.rs2_data;

    // operand select
    assign op_a  = (i_ex.opa_sel == rv_pkg::opa_zero) ? '0 : rs1_val;
    assign op_b  = i_ex.use_imm ? i_ex.imm : rs2_val;
    assign shamt = op_b[rv_pkg::shamt_w-1:0];

    // ------------------------------------------------------------
    // alu
    // ------------------------------------------------------------
    always_comb begin
        case (i_ex.alu_op)
            rv_pkg::alu_add:  result = op_a + op_b;
            rv_pkg::alu_sub:  result = op_a - op_b;
            rv_pkg::alu_and:  result = op_a & op_b;
            rv_pkg::alu_or:   result = op_a | op_b;
            rv_pkg::alu_xor:  result = op_a ^ op_b;
            rv_pkg::alu_slt: begin
                result = {{(rv_pkg::xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            rv_pkg::alu_sltu: begin
                result = {{(rv_pkg::xlen-1){1'b0}}, (op_a < op_b)};
            end
            rv_pkg::alu_sll:  result = op_a << shamt;
            rv_pkg::alu_srl:  result = op_a >> shamt;
            rv_pkg::alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
            default:          result = '0;
        endcase
    end

    always_comb begin
        o_wb.valid  = i_ex.valid;
        o_wb.rd     = i_ex.rd;
        o_wb.result = result;
    end

endmodule

/* design/rv_stage_reg.sv */
`timescale 1ns/1ps

// one pipeline register, shared by the ex and wb stages
module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_flush = 1'b0,   // left open on the wb instance
    input  payload_t i_d,
    output payload_t o_q
);

    // clearing the whole payload drops its valid bit
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_q <= '0;
        end else if (i_flush) begin
            o_q <= '0;
        end else begin
            o_q <= i_d;
        end
    end

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
    input  logic                          i_instr_valid,
    input  logic [rv_pkg::xlen-1:0]       i_instr,
    output logic [rv_pkg::reg_addr_w-1:0] o_rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] o_rs2_addr,
    input  logic [rv_pkg::xlen-1:0]       i_rs1_data,
    input  logic [rv_pkg::xlen-1:0]       i_rs2_data,
    output rv_pkg::ex_payload_t           o_ex
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic                          funct7_b30;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       imm_i;
    logic [rv_pkg::xlen-1:0]       imm_u;
    logic                          is_r_type;
    logic                          is_i_alu;
    logic                          is_lui;
    rv_pkg::alu_op_e               alu_op;

    // ------------------------------------------------------------
    // field split
    // ------------------------------------------------------------
    assign opcode     = i_instr[6:0];
    assign rd         = i_instr[11:7];
    assign funct3     = i_instr[14:12];
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];
    assign funct7_b30 = i_instr[30];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};

    assign is_r_type = (opcode == rv_pkg::op_r_type);
    assign is_i_alu  = (opcode == rv_pkg::op_i_alu);
    assign is_lui    = (opcode == rv_pkg::op_lui);

    // ------------------------------------------------------------
    // alu op select
    // ------------------------------------------------------------
    always_comb begin
        alu_op = rv_pkg::alu_add;
        case (funct3)
            rv_pkg::f3_add_sub: begin
                // bit 30 is imm on addi, only r-type has sub
                if (is_r_type && funct7_b30)
                    alu_op = rv_pkg::alu_sub;
                else
                    alu_op = rv_pkg::alu_add;
            end
            rv_pkg::f3_sll:  alu_op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  alu_op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu: alu_op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  alu_op = rv_pkg::alu_xor;
            rv_pkg::f3_srl_sra: begin
                if (funct7_b30)
                    alu_op = rv_pkg::alu_sra;   // srai keeps bit 30 too
                else
                    alu_op = rv_pkg::alu_srl;
            end
            rv_pkg::f3_or:   alu_op = rv_pkg::alu_or;
            rv_pkg::f3_and:  alu_op = rv_pkg::alu_and;
            default:         alu_op = rv_pkg::alu_add;
        endcase
        if (is_lui)
            alu_op = rv_pkg::alu_add;   // 0 + imm_u
    end

    // ------------------------------------------------------------
    // execute payload
    // ------------------------------------------------------------
    always_comb begin
        o_ex          = '0;
        o_ex.valid    = i_instr_valid && (is_r_type || is_i_alu || is_lui);
        o_ex.rs1      = o_rs1_addr;
        o_ex.rs2      = o_rs2_addr;
        o_ex.rd       = rd;
        o_ex.rs1_data = i_rs1_data;
        o_ex.rs2_data = i_rs2_data;
        o_ex.imm      = is_lui ? imm_u : imm_i;
        o_ex.alu_op   = alu_op;
        o_ex.opa_sel  = is_lui ? rv_pkg::opa_zero : rv_pkg::opa_rs1;
        o_ex.use_imm  = !is_r_type;
    end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic [rv_pkg::reg_addr_w-1:0] i_rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] i_rs2_addr,
    output logic [rv_pkg::xlen-1:0]       o_rs1_data,
    output logic [rv_pkg::xlen-1:0]       o_rs2_data,
    input  rv_pkg::wb_payload_t           i_wb
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::nregs];
    logic                    wr_en;

    assign wr_en = i_wb.valid && (i_wb.rd != '0);   // x0 writes dropped

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < rv_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.rd] <= i_wb.result;
        end
    end

    // write-through so decode sees the value retiring this cycle
    always_comb begin
        if (i_rs1_addr == '0)
            o_rs1_data = '0;
        else if (wr_en && (i_wb.rd == i_rs1_addr))
            o_rs1_data = i_wb.result;
        else
            o_rs1_data = regs[i_rs1_addr];

        if (i_rs2_addr == '0)
            o_rs2_data = '0;
        else if (wr_en && (i_wb.rd == i_rs2_addr))
            o_rs2_data = i_wb.result;
        else
            o_rs2_data = regs[i_rs2_addr];
    end

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;
    localparam int shamt_w    = 5;   // shift amount, low bits of operand b

    // ------------------------------------------------------------
    // opcodes and funct3 codes of the supported groups
    // ------------------------------------------------------------
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_alu  = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // zero is only picked by lui
    typedef enum logic {
        opa_rs1  = 1'b0,
        opa_zero = 1'b1
    } opa_sel_e;

    // ------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        alu_op_e               alu_op;
        opa_sel_e              opa_sel;
        logic                  use_imm;   // operand b from imm instead of rs2
    } ex_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } wb_payload_t;

endpackage
